// File: int_issue_top.f
+incdir+include
logic/int_issue_pkg.sv
logic/fu_alu.sv
logic/phys_reg_file.sv
logic/int_rs.sv
logic/int_issue_top.sv
tb/int_issue_asserts.sv
tb/int_issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status carries pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f int_issue_top.f --top-module int_issue_tb -o sim_int_issue \
    && ./obj_dir/sim_int_issue \
    || exit 1

// File: tb/int_issue_tb.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module int_issue_tb;
    import int_issue_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    localparam int N_INDEP    = 20;
    localparam int N_RAND     = 60;
    // directed groups: back-to-back 5, full stations 9, latency 2
    localparam int N_OPS      = N_INDEP + N_RAND + 5 + 9 + 2;
    localparam int TIMEOUT    = (RST_CYCLES + 40 * N_OPS) * CLK_PERIOD;
    localparam int N_TAGS     = 2**`PHY_TAG_W;
    localparam int N_ROB      = 2**`ROB_ID_W;

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    uop_t disp_uop;
    cdb_t completion;

    logic [16:0]           lfsr;
    logic [`XLEN-1:0]      ref_val [N_TAGS];
    bit                    tag_ready [N_TAGS];
    int                    readers [N_TAGS];
    logic [`XLEN-1:0]      exp_val [N_ROB];
    logic [`PHY_TAG_W-1:0] exp_tag [N_ROB];
    bit                    rob_pending [N_ROB];
    int                    src1_of [N_ROB];
    int                    src2_of [N_ROB];
    bit                    chk_lat [N_ROB];
    time                   disp_edge [N_ROB];
    int                    next_tag;
    int                    next_rob;
    int                    n_disp;
    int                    n_comp;
    bit                    full_seen;
    int                    last_dst;

    int_issue_top u_int_issue_top (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_uop   (disp_uop),
        .disp_ready (disp_ready),
        .completion (completion)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////
    // helpers
    ////////////////////////////////

    // fibonacci lfsr, taps 17 and 14
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // expected alu result
    function automatic logic [`XLEN-1:0] alu_ref(input alu_op_e op,
                                                 input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU: return (a < b) ? 1 : 0;
            default:  return '0;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] expected,
                               input string name);
        if (got !== expected) begin
            report_fail($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    task automatic check_tag(input logic [`PHY_TAG_W-1:0] got,
                             input logic [`PHY_TAG_W-1:0] expected, input string name);
        if (got !== expected) begin
            report_fail($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, expected));
        end
    endtask

    // allocate rob id and tag, compute result in program order
    task automatic prepare(input alu_op_e op, input op1_sel_e s1, input op2_sel_e s2,
                           input int rs1, input int rs2, input logic [31:0] imm,
                           output uop_t u);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        int               dst;
        int               rob;
        while (rob_pending[next_rob]) begin
            @(posedge clk);
            #2;
        end
        while (!tag_ready[next_tag] || readers[next_tag] != 0) begin
            @(posedge clk);
            #2;
        end
        dst      = next_tag;
        rob      = next_rob;
        next_tag = (next_tag == N_TAGS - 1) ? 8 : next_tag + 1;
        next_rob = (next_rob + 1) % N_ROB;
        if (rs1 == dst || s1 != OP1_RS1) rs1 = 0;
        if (rs2 == dst || s2 != OP2_RS2) rs2 = 0;

        u           = '0;
        u.rob_id    = rob;
        u.rd_phy    = dst;
        u.rs1_phy   = rs1;
        u.rs2_phy   = rs2;
        u.rs1_valid = tag_ready[rs1];
        u.rs2_valid = tag_ready[rs2];
        u.op1_sel   = s1;
        u.op2_sel   = s2;
        u.alu_op    = op;
        u.imm       = imm;
        u.pc        = rand_bits(32) & 32'hffff_fffc;

        a = (s1 == OP1_RS1) ? ref_val[rs1] : (s1 == OP1_PC) ? u.pc : '0;
        b = (s2 == OP2_RS2) ? ref_val[rs2] : (s2 == OP2_IMM) ? imm : '0;
        exp_val[rob]     = alu_ref(op, a, b);
        exp_tag[rob]     = dst;
        rob_pending[rob] = 1'b1;
        chk_lat[rob]     = 1'b0;
        src1_of[rob]     = (s1 == OP1_RS1) ? rs1 : -1;
        src2_of[rob]     = (s2 == OP2_RS2) ? rs2 : -1;
        if (s1 == OP1_RS1) readers[rs1]++;
        if (s2 == OP2_RS2) readers[rs2]++;
        ref_val[dst]   = exp_val[rob];
        tag_ready[dst] = 1'b0;
        last_dst       = dst;
    endtask

    // called 2 ns after an edge, returns 2 ns after the push edge
    task automatic push(input uop_t u, input bit lat);
        bit  done;
        time edge_t;
        done       = 1'b0;
        disp_uop   = u;
        disp_valid = 1'b1;
        while (!done) begin
            edge_t = $time - 2;
            // ready depends on state only, so it holds until the edge
            if (disp_ready) begin
                done = 1'b1;
                @(posedge clk);
            end else begin
                full_seen = 1'b1;
                @(posedge clk);
                #2;
                if (tag_ready[disp_uop.rs1_phy]) disp_uop.rs1_valid = 1'b1;
                if (tag_ready[disp_uop.rs2_phy]) disp_uop.rs2_valid = 1'b1;
            end
        end
        disp_edge[u.rob_id] = edge_t;
        chk_lat[u.rob_id]   = lat;
        n_disp++;
        #2;
        disp_valid = 1'b0;
    endtask

    task automatic drain();
        while (n_comp != n_disp) begin
            @(posedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    ////////////////////////////////
    // completion monitor
    ////////////////////////////////

    initial begin
        int rob;
        forever begin
            @(negedge clk);
            if (!rst && completion.valid) begin
                rob = completion.rob_id;
                if (!rob_pending[rob]) begin
                    report_fail("completion arrived for a rob id with no op in flight");
                end else begin
                    check_tag(completion.rd_phy, exp_tag[rob], "completion.rd_phy");
                    check_value(completion.value, exp_val[rob], "completion.value");
                    // valid rose half a period before this sample
                    if (chk_lat[rob] && ($time - 10 - disp_edge[rob]) != 2 * CLK_PERIOD) begin
                        report_fail("ready op did not complete two cycles after dispatch");
                    end
                    tag_ready[completion.rd_phy] = 1'b1;
                    if (src1_of[rob] >= 0) readers[src1_of[rob]]--;
                    if (src2_of[rob] >= 0) readers[src2_of[rob]]--;
                    rob_pending[rob] = 1'b0;
                    n_comp++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT);
        report_fail("timeout, the ops did not all complete in time");
    end

    ////////////////////////////////
    // stimulus
    ////////////////////////////////

    initial begin
        uop_t u;
        uop_t p;
        uop_t f;
        uop_t c;
        uop_t cons [7];
        rst        = 1'b1;
        disp_valid = 1'b0;
        disp_uop   = '0;
        lfsr       = 17'd95184;
        next_tag   = 8;
        next_rob   = 0;
        n_disp     = 0;
        n_comp     = 0;
        full_seen  = 1'b0;
        last_dst   = 0;
        for (int i = 0; i < N_TAGS; i++) begin
            ref_val[i]   = '0;
            tag_ready[i] = 1'b1;
            readers[i]   = 0;
        end
        for (int i = 0; i < N_ROB; i++) begin
            rob_pending[i] = 1'b0;
            chk_lat[i]     = 1'b0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // independent ops, every opcode
        for (int i = 0; i < N_INDEP; i++) begin
            prepare(alu_op_e'(i % 10), (i % 2) ? OP1_ZERO : OP1_PC,
                    (i % 5 == 4) ? OP2_ZERO : OP2_IMM, 0, 0, rand_bits(32), u);
            push(u, 1'b0);
        end

        // random mix with dependency chains
        for (int i = 0; i < N_RAND; i++) begin
            int sa;
            int sb;
            int r1;
            int r2;
            sa = rand_bits(2);
            sb = rand_bits(2);
            r1 = rand_bits(1) ? last_dst : int'(rand_bits(5));
            r2 = rand_bits(1) ? last_dst : int'(rand_bits(5));
            prepare(alu_op_e'(rand_bits(4) % 10),
                    (sa == 3) ? OP1_RS1 : op1_sel_e'(sa),
                    (sb == 3) ? OP2_RS2 : op2_sel_e'(sb), r1, r2, rand_bits(32), u);
            push(u, 1'b0);
        end

        // consumer right behind producer, woken with bypass
        drain();
        prepare(ALU_ADD, OP1_ZERO, OP2_IMM, 0, 0, rand_bits(32), p);
        prepare(ALU_SUB, OP1_RS1, OP2_IMM, p.rd_phy, 0, rand_bits(32), c);
        push(p, 1'b0);
        push(c, 1'b0);

        // consumer pushed while producer is on the cdb
        drain();
        prepare(ALU_XOR, OP1_PC, OP2_IMM, 0, 0, rand_bits(32), p);
        prepare(ALU_OR, OP1_ZERO, OP2_IMM, 0, 0, rand_bits(32), f);
        prepare(ALU_ADD, OP1_RS1, OP2_RS2, p.rd_phy, p.rd_phy, 0, c);
        push(p, 1'b0);
        push(f, 1'b0);
        push(c, 1'b0);

        // seven waiting ops plus their late producer fill the stations
        drain();
        prepare(ALU_ADD, OP1_ZERO, OP2_IMM, 0, 0, rand_bits(32), p);
        for (int i = 0; i < 7; i++) begin
            prepare(alu_op_e'(i), OP1_RS1, (i % 2) ? OP2_RS2 : OP2_IMM,
                    p.rd_phy, p.rd_phy, rand_bits(32), cons[i]);
        end
        for (int i = 0; i < 7; i++) begin
            push(cons[i], 1'b0);
        end
        push(p, 1'b0);
        prepare(ALU_SLTU, OP1_PC, OP2_IMM, 0, 0, rand_bits(32), u);
        push(u, 1'b0);

        // minimum latency from an empty station array
        for (int i = 0; i < 2; i++) begin
            drain();
            prepare(ALU_OR, OP1_PC, OP2_IMM, 0, 0, rand_bits(32), u);
            push(u, 1'b1);
        end

        drain();
        repeat (5) @(posedge clk);
        if (!full_seen || n_disp != n_comp) begin
            report_fail("stations never filled or dispatch and completion counts differ");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: tb/int_issue_asserts.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module int_issue_asserts (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 disp_ready,
    input  logic                 push_en,
    input  logic                 issue_valid,
    input  logic [`RS_DEPTH-1:0] rs_free
);

    // occupancy counted from the push and issue events
    logic [`RS_IDX_W:0] occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            occ <= '0;
        end else begin
            occ <= occ + {{`RS_IDX_W{1'b0}}, push_en} - {{`RS_IDX_W{1'b0}}, issue_valid};
        end
    end

    // ready low exactly when every station holds an op
    a_ready_full: assert property (@(posedge clk) disable iff (rst)
        (!disp_ready) == (occ == `RS_DEPTH))
        else $error("disp_ready disagrees with station occupancy");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push_en |-> (occ < `RS_DEPTH))
        else $error("push accepted with all stations occupied");

    // issuing a free slot leaves the flags and the count apart
    a_issue_occupied: assert property (@(posedge clk) disable iff (rst)
        issue_valid |=> ($countones(~rs_free) == occ))
        else $error("issue selected a free station");

endmodule

bind int_rs int_issue_asserts u_int_issue_asserts (
    .clk         (clk),
    .rst         (rst),
    .disp_ready  (disp_ready),
    .push_en     (push_en),
    .issue_valid (issue_valid),
    .rs_free     (rs_free)
);

// File: logic/int_issue_top.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module int_issue_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                disp_valid,
    input  int_issue_pkg::uop_t disp_uop,
    output logic                disp_ready,

    output int_issue_pkg::cdb_t completion
);
    import int_issue_pkg::*;

    // station to register file read
    logic [`PHY_TAG_W-1:0] rs1_phy;
    logic [`PHY_TAG_W-1:0] rs2_phy;
    logic [`XLEN-1:0]      rs1_value;
    logic [`XLEN-1:0]      rs2_value;

    // station to alu
    logic                  issue_valid;
    alu_issue_t            issue;

    // broadcast back to everyone
    cdb_t                  cdb;

    int_rs u_int_rs (
        .clk         (clk),
        .rst         (rst),
        .disp_valid  (disp_valid),
        .disp_uop    (disp_uop),
        .disp_ready  (disp_ready),
        .cdb         (cdb),
        .rs1_phy     (rs1_phy),
        .rs2_phy     (rs2_phy),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    phys_reg_file u_phys_reg_file (
        .clk       (clk),
        .rst       (rst),
        .cdb       (cdb),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    fu_alu u_fu_alu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .cdb         (cdb)
    );

    assign completion = cdb;

endmodule

// File: logic/int_rs.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module int_rs (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      disp_valid,
    input  int_issue_pkg::uop_t       disp_uop,
    output logic                      disp_ready,

    input  int_issue_pkg::cdb_t       cdb,

    output logic [`PHY_TAG_W-1:0]     rs1_phy,
    output logic [`PHY_TAG_W-1:0]     rs2_phy,
    input  logic [`XLEN-1:0]          rs1_value,
    input  logic [`XLEN-1:0]          rs2_value,

    output logic                      issue_valid,
    output int_issue_pkg::alu_issue_t issue
);
    import int_issue_pkg::*;

    // station storage, payload has no reset
    uop_t                 rs_array [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] rs_free;

    logic                 push_en;
    logic [`RS_IDX_W-1:0] push_idx;
    uop_t                 push_uop;

    logic [`RS_DEPTH-1:0] src1_rdy;
    logic [`RS_DEPTH-1:0] src2_rdy;
    logic [`RS_DEPTH-1:0] slot_ready;
    logic [`RS_IDX_W-1:0] issue_idx;

    // lowest set bit, shared by push and issue select
    function automatic logic [`RS_IDX_W-1:0] lowest_idx(input logic [`RS_DEPTH-1:0] vec);
        logic [`RS_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = (`RS_IDX_W)'(unsigned'(i));
            end
        end
        return idx;
    endfunction

    //////////////////////////////
    // dispatch side
    //////////////////////////////

    assign disp_ready = |rs_free;
    assign push_en    = disp_valid && disp_ready;
    assign push_idx   = lowest_idx(rs_free);

    // catch a producer broadcasting in the push cycle
    always_comb begin
        push_uop = disp_uop;
        if (cdb.valid && cdb.rd_phy == disp_uop.rs1_phy) begin
            push_uop.rs1_valid = 1'b1;
        end
        if (cdb.valid && cdb.rd_phy == disp_uop.rs2_phy) begin
            push_uop.rs2_valid = 1'b1;
        end
    end

    //////////////////////////////
    // station update
    //////////////////////////////

    always_ff @(posedge clk) begin
        // wakeup of waiting sources
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (cdb.valid && !rs_free[i]) begin
                if (rs_array[i].rs1_phy == cdb.rd_phy) begin
                    rs_array[i].rs1_valid <= 1'b1;
                end
                if (rs_array[i].rs2_phy == cdb.rd_phy) begin
                    rs_array[i].rs2_valid <= 1'b1;
                end
            end
        end
        if (push_en) begin
            rs_array[push_idx] <= push_uop;
        end
    end

    // push and issue never hit the same slot
    always_ff @(posedge clk) begin
        if (rst) begin
            rs_free <= '1;
        end else begin
            if (push_en) begin
                rs_free[push_idx] <= 1'b0;
            end
            if (issue_valid) begin
                rs_free[issue_idx] <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // issue select
    //////////////////////////////

    // non-register sources are always ready, cdb hit counts this cycle
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            src1_rdy[i] = (rs_array[i].op1_sel != OP1_RS1) || rs_array[i].rs1_valid ||
                          (cdb.valid && cdb.rd_phy == rs_array[i].rs1_phy);
            src2_rdy[i] = (rs_array[i].op2_sel != OP2_RS2) || rs_array[i].rs2_valid ||
                          (cdb.valid && cdb.rd_phy == rs_array[i].rs2_phy);
        end
    end

    assign slot_ready  = ~rs_free & src1_rdy & src2_rdy;
    assign issue_valid = |slot_ready;
    assign issue_idx   = lowest_idx(slot_ready);

    // register file read for the selected slot
    assign rs1_phy = rs_array[issue_idx].rs1_phy;
    assign rs2_phy = rs_array[issue_idx].rs2_phy;

    always_comb begin
        issue.rob_id    = rs_array[issue_idx].rob_id;
        issue.rd_phy    = rs_array[issue_idx].rd_phy;
        issue.op1_sel   = rs_array[issue_idx].op1_sel;
        issue.op2_sel   = rs_array[issue_idx].op2_sel;
        issue.alu_op    = rs_array[issue_idx].alu_op;
        issue.imm       = rs_array[issue_idx].imm;
        issue.pc        = rs_array[issue_idx].pc;
        issue.rs1_value = rs1_value;
        issue.rs2_value = rs2_value;
    end

endmodule

// File: logic/phys_reg_file.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module phys_reg_file (
    input  logic                  clk,
    input  logic                  rst,

    input  int_issue_pkg::cdb_t   cdb,

    input  logic [`PHY_TAG_W-1:0] rs1_phy,
    input  logic [`PHY_TAG_W-1:0] rs2_phy,
    output logic [`XLEN-1:0]      rs1_value,
    output logic [`XLEN-1:0]      rs2_value
);
    import int_issue_pkg::*;

    logic [`XLEN-1:0] regs [2**`PHY_TAG_W];

    // write port driven by the cdb
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**`PHY_TAG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb.valid) begin
            regs[cdb.rd_phy] <= cdb.value;
        end
    end

    //////////////////////////////
    // read ports with bypass
    //////////////////////////////

    always_comb begin
        if (cdb.valid && cdb.rd_phy == rs1_phy) begin
            rs1_value = cdb.value;
        end else begin
            rs1_value = regs[rs1_phy];
        end

        if (cdb.valid && cdb.rd_phy == rs2_phy) begin
            rs2_value = cdb.value;
        end else begin
            rs2_value = regs[rs2_phy];
        end
    end

endmodule

// File: logic/fu_alu.sv
`timescale 1ns/1ns
`include "int_issue_macros.svh"

module fu_alu (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      issue_valid,
    input  int_issue_pkg::alu_issue_t issue,

    output int_issue_pkg::cdb_t       cdb
);
    import int_issue_pkg::*;

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    //////////////////////////////
    // operand select
    //////////////////////////////

    always_comb begin
        case (issue.op1_sel)
            OP1_RS1: op1 = issue.rs1_value;
            OP1_PC:  op1 = issue.pc;
            default: op1 = '0;
        endcase

        case (issue.op2_sel)
            OP2_RS2: op2 = issue.rs2_value;
            OP2_IMM: op2 = issue.imm;
            default: op2 = '0;
        endcase
    end

    // shifts use the low five bits only
    assign shamt = op2[4:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  result = op1 + op2;
            ALU_SUB:  result = op1 - op2;
            ALU_AND:  result = op1 & op2;
            ALU_OR:   result = op1 | op2;
            ALU_XOR:  result = op1 ^ op2;
            ALU_SLL:  result = op1 << shamt;
            ALU_SRL:  result = op1 >> shamt;
            ALU_SRA:  result = $signed(op1) >>> shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, op1 < op2};
            default:  result = '0;
        endcase
    end

    // one cycle to the bus, only valid is reset
    always_ff @(posedge clk) begin
        cdb.rob_id <= issue.rob_id;
        cdb.rd_phy <= issue.rd_phy;
        cdb.value  <= result;
        if (rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
    end

endmodule

// File: logic/int_issue_pkg.sv
`include "int_issue_macros.svh"

package int_issue_pkg;

    //////////////////////////////
    // opcodes and selects
    //////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM,
        OP2_ZERO
    } op2_sel_e;

    //////////////////////////////
    // bundles
    //////////////////////////////

    // renamed micro-op from dispatch
    typedef struct packed {
        logic [`ROB_ID_W-1:0]  rob_id;
        logic [`PHY_TAG_W-1:0] rd_phy;
        logic [`PHY_TAG_W-1:0] rs1_phy;
        logic                  rs1_valid;
        logic [`PHY_TAG_W-1:0] rs2_phy;
        logic                  rs2_valid;
        op1_sel_e              op1_sel;
        op2_sel_e              op2_sel;
        alu_op_e               alu_op;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      pc;
    } uop_t;

    // issued op plus its register file reads
    typedef struct packed {
        logic [`ROB_ID_W-1:0]  rob_id;
        logic [`PHY_TAG_W-1:0] rd_phy;
        op1_sel_e              op1_sel;
        op2_sel_e              op2_sel;
        alu_op_e               alu_op;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_value;
        logic [`XLEN-1:0]      rs2_value;
    } alu_issue_t;

    // common data bus broadcast
    typedef struct packed {
        logic                  valid;
        logic [`ROB_ID_W-1:0]  rob_id;
        logic [`PHY_TAG_W-1:0] rd_phy;
        logic [`XLEN-1:0]      value;
    } cdb_t;

endpackage

// File: include/int_issue_macros.svh
`ifndef INT_ISSUE_MACROS_SVH
`define INT_ISSUE_MACROS_SVH

// datapath width
`define XLEN 32

// physical register tags, 32 physical registers
`define PHY_TAG_W 5

// reservation station sizing
`define RS_DEPTH 8
`define RS_IDX_W 3

// reorder buffer id carried through to completion
`define ROB_ID_W 4

`endif
